/* mmc3_mapper.f */
+incdir+dv
design/mmc3_pkg.sv
design/mmc3_regs.sv
design/mmc3_prg_map.sv
design/mmc3_chr_map.sv
design/mmc3_scanline_irq.sv
design/mmc3_mapper.sv
dv/mmc3_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the MMC3 mapper testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module mmc3_tb -f mmc3_mapper.f -o mmc3_sim
sim_out=$(./obj_dir/mmc3_sim)
echo "$sim_out"
if echo "$sim_out" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1

/* dv/mmc3_tb_tasks.svh */
// --------------------
// MMC3 testbench tasks
// Bus access, LFSR stimulus, expected values and directed tests
// --------------------
`ifndef MMC3_TB_TASKS_SVH
`define MMC3_TB_TASKS_SVH

	// Galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_random(input int nbits, output logic [15:0] v);
		v = '0;
		repeat (nbits) begin
			v          = {v[14:0], lfsr_state[0]};  // One step per bit
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		$display("[FAIL] %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
		errors++;
	endtask

	task automatic finish_test(input string name, input int err_start);
		if (errors == err_start) begin
			tests_passed++;
			$display("[PASS] %s", name);
		end else begin
			tests_failed++;
			$display("[DONE] %s with %0d errors", name, errors - err_start);
		end
	endtask

	// Returns at the edge where the n-th strobe was taken
	task automatic wait_ce(input int n);
		repeat (n) begin
			do
				@(posedge clk);
			while (ce !== 1'b1);
		end
	endtask

	task automatic bus_write(input cpu_addr_t addr, input logic [7:0] data);
		@(posedge clk);
		prg_ain   <= addr;
		prg_din   <= data;
		prg_write <= 1'b1;
		wait_ce(1);                     // Held through one ce clock
		prg_write <= 1'b0;
	endtask

	task automatic cpu_access(input cpu_addr_t addr, input logic wr);
		@(posedge clk);
		prg_ain   <= addr;
		prg_write <= wr;
		@(negedge clk);                 // Mapped outputs settled
	endtask

	task automatic ppu_access(input ppu_addr_t addr);
		@(posedge clk);
		chr_ain <= addr;
		@(negedge clk);
	endtask

	// A12 low for low_ce strobes, then high for two
	task automatic a12_pulse(input int low_ce);
		@(posedge clk);
		chr_ain <= 14'h0000;
		wait_ce(low_ce);
		chr_ain <= 14'h1000;
		wait_ce(2);
		chr_ain <= 14'h0000;
		@(negedge clk);
	endtask

	// Window 0-3 is $8000, $A000, $C000, $E000
	function automatic prg_bank_t prg_window_bank(input logic mode, input logic [1:0] win,
		input prg_bank_t r6, input prg_bank_t r7);
		case (win)
			2'd0:    return mode ? 6'd62 : r6;
			2'd1:    return r7;
			2'd2:    return mode ? r6 : 6'd62;
			default: return 6'd63;
		endcase
	endfunction

	function automatic out_addr_t chr_expect(input ppu_addr_t a, input logic inv);
		logic [7:0] bank;
		if (a[12] ^ inv)
			bank = chr_regs[{1'b0, a[11:10]} + 3'd2];          // 1 KB half, R2-R5
		else
			bank = {chr_regs[{2'b00, a[11]}][7:1], a[10]};    // 2 KB half
		return {3'b100, 1'b0, bank, a[9:0]};
	endfunction

	task automatic test_reset_state();
		int err_start;
		err_start = errors;
		cpu_access(16'hE123, 1'b0);
		if (prg_aout !== {3'b000, 6'd63, 13'h0123})
			report_mismatch("$E000 after reset", 32'(prg_aout), 32'({3'b000, 6'd63, 13'h0123}));
		cpu_access(16'hC456, 1'b0);
		if (prg_aout !== {3'b000, 6'd62, 13'h0456})
			report_mismatch("$C000 after reset", 32'(prg_aout), 32'({3'b000, 6'd62, 13'h0456}));
		if (irq !== 1'b0)
			report_mismatch("irq after reset", 32'(irq), 32'd0);
		cpu_access(16'h6000, 1'b0);
		if (prg_allow !== 1'b0)
			report_mismatch("RAM allow after reset", 32'(prg_allow), 32'd0);
		ppu_access(14'h2400);
		if (vram_a10 !== 1'b1)
			report_mismatch("vram_a10 at $2400", 32'(vram_a10), 32'd1);
		ppu_access(14'h2800);
		if (vram_a10 !== 1'b0)
			report_mismatch("vram_a10 at $2800", 32'(vram_a10), 32'd0);
		finish_test("reset state", err_start);
	endtask

	task automatic test_prg_banking();
		logic [15:0] rnd;
		prg_bank_t   r6;
		prg_bank_t   r7;
		cpu_addr_t   a;
		out_addr_t   exp;
		int          err_start;
		err_start = errors;
		take_random(8, rnd);
		r6 = rnd[5:0];                  // Upper data bits unused
		bus_write(16'h8000, 8'h06);
		bus_write(16'h8001, rnd[7:0]);
		take_random(8, rnd);
		r7 = rnd[5:0];
		bus_write(16'h8000, 8'h07);
		bus_write(16'h8001, rnd[7:0]);
		for (int mode = 0; mode < 2; mode++) begin
			bus_write(16'h8000, (mode != 0) ? 8'h47 : 8'h07);
			for (int win = 0; win < 4; win++) begin
				take_random(13, rnd);
				a = {1'b1, 2'(win), rnd[12:0]};
				cpu_access(a, 1'b0);
				exp = {3'b000, prg_window_bank(mode[0], 2'(win), r6, r7), a[12:0]};
				if (prg_aout !== exp)
					report_mismatch($sformatf("PRG mode %0d window %0d", mode, win),
						32'(prg_aout), 32'(exp));
				if (prg_allow !== 1'b1)
					report_mismatch("ROM read allow", 32'(prg_allow), 32'd1);
			end
		end
		finish_test("PRG banking", err_start);
	endtask

	task automatic test_chr_banking();
		logic [15:0] rnd;
		logic [2:0]  r;
		logic [3:0]  region;
		ppu_addr_t   a;
		out_addr_t   exp;
		int          err_start;
		err_start = errors;
		for (r = 3'd0; r < 3'd6; r++) begin
			take_random(8, rnd);
			if (r < 3'd2)
				rnd[0] = 1'b1;          // Must be dropped for R0 and R1
			chr_regs[r] = rnd[7:0];
			bus_write(16'h8000, {5'b00000, r});
			bus_write(16'h8001, rnd[7:0]);
		end
		for (int inv = 0; inv < 2; inv++) begin
			bus_write(16'h8000, (inv != 0) ? 8'h80 : 8'h00);
			for (region = 4'd0; region < 4'd8; region++) begin
				take_random(10, rnd);
				a = {1'b0, region[2:0], rnd[9:0]};
				ppu_access(a);
				exp = chr_expect(a, inv[0]);
				if (chr_aout !== exp)
					report_mismatch($sformatf("CHR inv %0d region %0d", inv, region),
						32'(chr_aout), 32'(exp));
			end
		end
		finish_test("CHR banking", err_start);
	endtask

	task automatic test_mirroring();
		logic [3:0] k;
		ppu_addr_t  a;
		logic       exp_a10;
		int         err_start;
		err_start = errors;
		for (int horiz = 0; horiz < 2; horiz++) begin
			bus_write(16'hA000, (horiz != 0) ? 8'h01 : 8'h00);
			for (k = 4'd0; k < 4'd8; k++) begin
				a = {k[2], 1'b0, k[1:0], 10'h155};  // A13 and A11:10 swept
				ppu_access(a);
				exp_a10 = (horiz != 0) ? a[11] : a[10];
				if (vram_a10 !== exp_a10)
					report_mismatch($sformatf("vram_a10 at $%h", a), 32'(vram_a10),
						32'(exp_a10));
				if (vram_ce !== a[13])
					report_mismatch($sformatf("vram_ce at $%h", a), 32'(vram_ce), 32'(a[13]));
			end
		end
		ppu_access(14'h0000);
		if (chr_allow !== 1'b0)
			report_mismatch("chr_allow for CHR ROM", 32'(chr_allow), 32'd0);
		@(posedge clk);
		chr_ram <= 1'b1;
		@(negedge clk);
		if (chr_allow !== 1'b1)
			report_mismatch("chr_allow for CHR RAM", 32'(chr_allow), 32'd1);
		finish_test("mirroring and CIRAM", err_start);
	endtask

	task automatic test_prg_ram();
		out_addr_t ram_exp;
		int        err_start;
		err_start = errors;
		ram_exp = {9'h1E0, 13'h1ABC};   // RAM prefix then A12:0
		bus_write(16'hA001, 8'h80);     // Enabled, writable
		cpu_access(16'h7ABC, 1'b1);
		if (prg_allow !== 1'b1)
			report_mismatch("RAM write allow", 32'(prg_allow), 32'd1);
		if (prg_aout !== ram_exp)
			report_mismatch("RAM write address", 32'(prg_aout), 32'(ram_exp));
		bus_write(16'hA001, 8'hC0);     // Write protected
		cpu_access(16'h7ABC, 1'b1);
		if (prg_allow !== 1'b0)
			report_mismatch("protected RAM write allow", 32'(prg_allow), 32'd0);
		cpu_access(16'h7ABC, 1'b0);
		if (prg_allow !== 1'b1)
			report_mismatch("protected RAM read allow", 32'(prg_allow), 32'd1);
		if (prg_aout !== ram_exp)
			report_mismatch("RAM read address", 32'(prg_aout), 32'(ram_exp));
		bus_write(16'hA001, 8'h00);
		cpu_access(16'h6010, 1'b0);
		if (prg_allow !== 1'b0)
			report_mismatch("disabled RAM allow", 32'(prg_allow), 32'd0);
		finish_test("PRG RAM", err_start);
	endtask

	task automatic test_scanline_irq();
		logic exp_irq;
		int   err_start;
		err_start = errors;
		@(posedge clk);
		chr_ain <= 14'h0000;
		wait_ce(A12_FILTER_LEN + 2);   // Filter drains to zero
		bus_write(16'hC000, 8'(IRQ_LATCH));
		bus_write(16'hC001, 8'h00);
		bus_write(16'hE001, 8'h00);
		for (int p = 1; p <= IRQ_LATCH + 1; p++) begin
			a12_pulse(A12_FILTER_LEN + 2);
			exp_irq = (p == IRQ_LATCH + 1);    // First pulse loads the latch
			if (irq !== exp_irq)
				report_mismatch($sformatf("irq after pulse %0d", p), 32'(irq), 32'(exp_irq));
		end
		bus_write(16'hE000, 8'h00);
		@(negedge clk);
		if (irq !== 1'b0)
			report_mismatch("irq after $E000", 32'(irq), 32'd0);
		bus_write(16'hC000, 8'h01);
		bus_write(16'hC001, 8'h00);
		bus_write(16'hE001, 8'h00);
		a12_pulse(A12_FILTER_LEN + 2);         // Loads 1
		if (irq !== 1'b0)
			report_mismatch("irq after reload pulse", 32'(irq), 32'd0);
		a12_pulse(A12_FILTER_LEN / 2);         // Inside the filter window
		if (irq !== 1'b0)
			report_mismatch("irq after short pulse", 32'(irq), 32'd0);
		a12_pulse(A12_FILTER_LEN + 2);
		if (irq !== 1'b1)
			report_mismatch("irq after wide pulse", 32'(irq), 32'd1);
		bus_write(16'hE000, 8'h00);
		@(negedge clk);
		if (irq !== 1'b0)
			report_mismatch("irq after second $E000", 32'(irq), 32'd0);
		finish_test("scanline IRQ", err_start);
	endtask

`endif

/* dv/mmc3_tb.sv */
// --------------------
// MMC3 mapper testbench
// Directed tests for banking, mirroring, PRG RAM and scanline IRQ
// --------------------
`default_nettype none

module mmc3_tb
	import mmc3_pkg::*;
();

	localparam int CLK_PERIOD     = 8;
	localparam int CE_TIME        = 4 * CLK_PERIOD;     // One CPU cycle
	localparam int A12_FILTER_LEN = 15;
	localparam int IRQ_LATCH      = 3;                  // Scanlines before the first IRQ
	localparam int PULSE_CE       = A12_FILTER_LEN + 4; // Wide A12 pulse plus overhead
	// CPU cycles per test: reset, PRG, CHR, mirroring, RAM, IRQ
	localparam int TEST_CE        = 4 + 40 + 50 + 30 + 20 + 12 * PULSE_CE + 20;
	localparam int WATCHDOG_TIME  = 12 * CLK_PERIOD + 2 * TEST_CE * CE_TIME;

	logic       clk       = 1'b0;
	logic       rst_n     = 1'b0;
	logic       ce        = 1'b0;
	logic [1:0] ce_div    = 2'd0;   // Clock divider for the CPU strobe
	cpu_addr_t  prg_ain   = '0;
	logic       prg_write = 1'b0;
	logic [7:0] prg_din   = 8'h00;
	ppu_addr_t  chr_ain   = '0;
	logic       chr_ram   = 1'b0;
	out_addr_t  prg_aout;
	logic       prg_allow;
	out_addr_t  chr_aout;
	logic       chr_allow;
	logic       vram_a10;
	logic       vram_ce;
	logic       irq;

	int          errors       = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;
	logic [15:0] lfsr_state   = 16'd10;   // Stimulus seed
	logic [7:0]  chr_regs [0:5];          // R0-R5 as written

	always #(CLK_PERIOD / 2) clk = ~clk;

	// One ce clock in every four
	always @(posedge clk) begin
		ce_div <= ce_div + 2'd1;
		ce     <= (ce_div == 2'd3);
	end

	mmc3_mapper #(
		.A12_FILTER_LEN (A12_FILTER_LEN)
	) u_mmc3_mapper (
		.clk       (clk),
		.rst_n     (rst_n),
		.ce        (ce),
		.prg_ain   (prg_ain),
		.prg_write (prg_write),
		.prg_din   (prg_din),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow),
		.chr_ain   (chr_ain),
		.chr_ram   (chr_ram),
		.chr_aout  (chr_aout),
		.chr_allow (chr_allow),
		.vram_a10  (vram_a10),
		.vram_ce   (vram_ce),
		.irq       (irq)
	);

	`include "mmc3_tb_tasks.svh"

	// Ends a run that stalls
	initial begin
		#(WATCHDOG_TIME);
		$display("Timeout: the tests did not finish within %0d time units", WATCHDOG_TIME);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		repeat (8) @(posedge clk);      // Reset held 8 cycles
		rst_n <= 1'b1;
		test_reset_state();
		test_prg_banking();
		test_chr_banking();
		test_mirroring();
		test_prg_ram();
		test_scanline_irq();
		$display("Tests passed: %0d, tests failed: %0d, errors: %0d",
			tests_passed, tests_failed, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* design/mmc3_mapper.sv */
// --------------------
// MMC3 mapper top level
// Registers, PRG and CHR mapping, scanline IRQ
// --------------------
`default_nettype none

module mmc3_mapper
	import mmc3_pkg::*;
#(
	parameter int unsigned A12_FILTER_LEN = 15
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       ce,            // CPU cycle strobe
	input  cpu_addr_t  prg_ain,
	input  logic       prg_write,
	input  logic [7:0] prg_din,
	output out_addr_t  prg_aout,
	output logic       prg_allow,
	input  ppu_addr_t  chr_ain,
	input  logic       chr_ram,       // Cart config, CHR is RAM
	output out_addr_t  chr_aout,
	output logic       chr_allow,
	output logic       vram_a10,
	output logic       vram_ce,
	output logic       irq
);

	logic       prg_mode;
	logic       chr_invert;
	logic       mirror_horiz;
	logic       ram_enable;
	logic       ram_protect;
	prg_bank_t  prg_bank_0;
	prg_bank_t  prg_bank_1;
	chr_bank_t  chr_bank_0;
	chr_bank_t  chr_bank_1;
	chr_bank_t  chr_bank_2;
	chr_bank_t  chr_bank_3;
	chr_bank_t  chr_bank_4;
	chr_bank_t  chr_bank_5;
	logic       irq_latch_wr;     // One-clock strobes from the register file
	logic [7:0] irq_latch_val;
	logic       irq_reload_wr;
	logic       irq_disable_wr;
	logic       irq_enable_wr;

	mmc3_regs u_mmc3_regs (
		.clk            (clk),
		.rst_n          (rst_n),
		.ce             (ce),
		.prg_ain        (prg_ain),
		.prg_write      (prg_write),
		.prg_din        (prg_din),
		.prg_mode       (prg_mode),
		.chr_invert     (chr_invert),
		.mirror_horiz   (mirror_horiz),
		.ram_enable     (ram_enable),
		.ram_protect    (ram_protect),
		.prg_bank_0     (prg_bank_0),
		.prg_bank_1     (prg_bank_1),
		.chr_bank_0     (chr_bank_0),
		.chr_bank_1     (chr_bank_1),
		.chr_bank_2     (chr_bank_2),
		.chr_bank_3     (chr_bank_3),
		.chr_bank_4     (chr_bank_4),
		.chr_bank_5     (chr_bank_5),
		.irq_latch_wr   (irq_latch_wr),
		.irq_latch_val  (irq_latch_val),
		.irq_reload_wr  (irq_reload_wr),
		.irq_disable_wr (irq_disable_wr),
		.irq_enable_wr  (irq_enable_wr)
	);

	mmc3_prg_map u_mmc3_prg_map (
		.prg_ain     (prg_ain),
		.prg_write   (prg_write),
		.prg_mode    (prg_mode),
		.prg_bank_0  (prg_bank_0),
		.prg_bank_1  (prg_bank_1),
		.ram_enable  (ram_enable),
		.ram_protect (ram_protect),
		.prg_aout    (prg_aout),
		.prg_allow   (prg_allow)
	);

	mmc3_chr_map u_mmc3_chr_map (
		.chr_ain      (chr_ain),
		.chr_ram      (chr_ram),
		.chr_invert   (chr_invert),
		.mirror_horiz (mirror_horiz),
		.chr_bank_0   (chr_bank_0),
		.chr_bank_1   (chr_bank_1),
		.chr_bank_2   (chr_bank_2),
		.chr_bank_3   (chr_bank_3),
		.chr_bank_4   (chr_bank_4),
		.chr_bank_5   (chr_bank_5),
		.chr_aout     (chr_aout),
		.chr_allow    (chr_allow),
		.vram_a10     (vram_a10),
		.vram_ce      (vram_ce)
	);

	mmc3_scanline_irq #(
		.A12_FILTER_LEN (A12_FILTER_LEN)
	) u_mmc3_scanline_irq (
		.clk            (clk),
		.rst_n          (rst_n),
		.ce             (ce),
		.chr_a12        (chr_ain[12]),    // Filter samples A12 itself
		.irq_latch_wr   (irq_latch_wr),
		.irq_latch_val  (irq_latch_val),
		.irq_reload_wr  (irq_reload_wr),
		.irq_disable_wr (irq_disable_wr),
		.irq_enable_wr  (irq_enable_wr),
		.irq            (irq)
	);

endmodule

`default_nettype wire

/* design/mmc3_scanline_irq.sv */
// --------------------
// MMC3 scanline IRQ
// Filters PPU A12 rises and counts them down from the latch
// --------------------
`default_nettype none

module mmc3_scanline_irq #(
	parameter int unsigned A12_FILTER_LEN = 15    // CPU cycles A12 must stay low
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       ce,
	input  logic       chr_a12,         // PPU A12, raw
	input  logic       irq_latch_wr,
	input  logic [7:0] irq_latch_val,
	input  logic       irq_reload_wr,
	input  logic       irq_disable_wr,
	input  logic       irq_enable_wr,
	output logic       irq
);

	logic [3:0] a12_ctr;        // Low-time filter
	logic       a12_rise;       // Counted rise this cycle
	logic [7:0] irq_latch;      // Reload value
	logic [7:0] counter;        // Scanline counter
	logic [7:0] next_counter;
	logic       reload_pend;    // $C001 seen since the last counted rise
	logic       irq_enable;

	// Sprite fetches toggle A12 fast, only a rise after a long low counts
	assign a12_rise = ce && chr_a12 && (a12_ctr == 4'd0);

	assign next_counter = (counter == 8'd0 || reload_pend) ? irq_latch : counter - 8'd1;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			a12_ctr     <= '0;
			irq_latch   <= '0;
			counter     <= '0;
			reload_pend <= 1'b0;
			irq_enable  <= 1'b0;
			irq         <= 1'b0;
		end else begin
			if (ce) begin
				if (chr_a12)
					a12_ctr <= 4'(A12_FILTER_LEN);   // Hold off while high
				else if (a12_ctr != 4'd0)
					a12_ctr <= a12_ctr - 4'd1;
			end
			if (a12_rise) begin
				counter     <= next_counter;
				reload_pend <= 1'b0;
				if (next_counter == 8'd0 && irq_enable)
					irq <= 1'b1;                       // Normal behavior, fires on zero
			end
			if (irq_latch_wr)
				irq_latch <= irq_latch_val;
			if (irq_reload_wr)
				reload_pend <= 1'b1;                   // Wins over a rise in the same cycle
			if (irq_enable_wr)
				irq_enable <= 1'b1;
			if (irq_disable_wr) begin
				irq_enable <= 1'b0;
				irq        <= 1'b0;                    // Also acknowledges
			end
		end
	end

endmodule

`default_nettype wire

/* design/mmc3_chr_map.sv */
// --------------------
// MMC3 CHR mapper
// PPU address to CHR bank, nametable A10 and CIRAM select
// --------------------
`default_nettype none

module mmc3_chr_map
	import mmc3_pkg::*;
(
	input  ppu_addr_t chr_ain,
	input  logic      chr_ram,        // CHR is RAM on this cart
	input  logic      chr_invert,     // Swaps the 2 KB and 1 KB halves
	input  logic      mirror_horiz,
	input  chr_bank_t chr_bank_0,     // R0, bit 0 always clear
	input  chr_bank_t chr_bank_1,     // R1, bit 0 always clear
	input  chr_bank_t chr_bank_2,
	input  chr_bank_t chr_bank_3,
	input  chr_bank_t chr_bank_4,
	input  chr_bank_t chr_bank_5,
	output out_addr_t chr_aout,
	output logic      chr_allow,
	output logic      vram_a10,
	output logic      vram_ce
);

	logic      chr_half;  // 0 selects the 2 KB half
	chr_bank_t chr_sel;   // 1 KB bank for this access
	chr_bank_t a10_bit;

	assign chr_half = chr_ain[12] ^ chr_invert;
	assign a10_bit  = {7'b0, chr_ain[10]};

	always_comb begin
		case ({chr_half, chr_ain[11:10]})
			3'b0_00,
			3'b0_01: chr_sel = chr_bank_0 | a10_bit;   // A10 is the low bank bit
			3'b0_10,
			3'b0_11: chr_sel = chr_bank_1 | a10_bit;
			3'b1_00: chr_sel = chr_bank_2;
			3'b1_01: chr_sel = chr_bank_3;
			3'b1_10: chr_sel = chr_bank_4;
			default: chr_sel = chr_bank_5;
		endcase
	end

	// Pad bit keeps the 8-bit bank aligned in the 22-bit space
	assign chr_aout  = {CHR_BASE, 1'b0, chr_sel, chr_ain[9:0]};
	assign chr_allow = chr_ram;                       // Writes only to CHR RAM

	// Nametables live in the console's 2 KB CIRAM
	assign vram_a10 = mirror_horiz ? chr_ain[11] : chr_ain[10];
	assign vram_ce  = chr_ain[13];

endmodule

`default_nettype wire

/* design/mmc3_prg_map.sv */
// --------------------
// MMC3 PRG mapper
// CPU address to PRG ROM or PRG RAM, plus access permission
// --------------------
`default_nettype none

module mmc3_prg_map
	import mmc3_pkg::*;
(
	input  cpu_addr_t prg_ain,
	input  logic      prg_write,
	input  logic      prg_mode,     // 1 swaps $8000 and $C000
	input  prg_bank_t prg_bank_0,   // R6
	input  prg_bank_t prg_bank_1,   // R7
	input  logic      ram_enable,
	input  logic      ram_protect,
	output out_addr_t prg_aout,
	output logic      prg_allow
);

	prg_bank_t prg_sel;   // 8 KB bank for the current window
	logic      prg_is_ram;
	out_addr_t rom_addr;
	out_addr_t ram_addr;

	// Window is A14:13 inside $8000-$FFFF
	always_comb begin
		case ({prg_ain[14:13], prg_mode})
			3'b00_0: prg_sel = prg_bank_0;          // $8000 R6
			3'b00_1: prg_sel = PRG_SECOND_LAST;     // $8000 fixed
			3'b01_0,
			3'b01_1: prg_sel = prg_bank_1;          // $A000 R7 in both modes
			3'b10_0: prg_sel = PRG_SECOND_LAST;     // $C000 fixed
			3'b10_1: prg_sel = prg_bank_0;          // $C000 R6
			default: prg_sel = PRG_LAST_BANK;       // $E000 always last
		endcase
	end

	// $6000-$7FFF unless a write hits protected RAM
	assign prg_is_ram = (prg_ain[15:13] == 3'b011) && ram_enable
		&& !(ram_protect && prg_write);

	// ROM region has a zero prefix
	assign rom_addr = {3'b000, prg_sel, prg_ain[12:0]};
	assign ram_addr = {PRG_RAM_BASE, prg_ain[12:0]};    // 8 KB without banking

	assign prg_aout  = prg_is_ram ? ram_addr : rom_addr;
	assign prg_allow = (prg_ain[15] && !prg_write) || prg_is_ram;  // ROM is read only

endmodule

`default_nettype wire

/* design/mmc3_regs.sv */
// --------------------
// MMC3 CPU register file
// Decodes $8000-$FFFF writes into bank, mode and IRQ controls
// --------------------
`default_nettype none

module mmc3_regs
	import mmc3_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       ce,              // One strobe per CPU cycle
	input  cpu_addr_t  prg_ain,
	input  logic       prg_write,
	input  logic [7:0] prg_din,
	output logic       prg_mode,        // 1 swaps the $8000 and $C000 windows
	output logic       chr_invert,      // 1 puts the 1 KB banks at $0000
	output logic       mirror_horiz,    // 0 vertical, 1 horizontal
	output logic       ram_enable,      // PRG RAM chip enable
	output logic       ram_protect,     // PRG RAM write deny
	output prg_bank_t  prg_bank_0,      // R6
	output prg_bank_t  prg_bank_1,      // R7
	output chr_bank_t  chr_bank_0,      // R0, 2 KB
	output chr_bank_t  chr_bank_1,      // R1, 2 KB
	output chr_bank_t  chr_bank_2,      // R2
	output chr_bank_t  chr_bank_3,      // R3
	output chr_bank_t  chr_bank_4,      // R4
	output chr_bank_t  chr_bank_5,      // R5
	output logic       irq_latch_wr,    // $C000 even
	output logic [7:0] irq_latch_val,
	output logic       irq_reload_wr,   // $C001 odd
	output logic       irq_disable_wr,  // $E000 even
	output logic       irq_enable_wr    // $E001 odd
);

	logic       reg_wr;       // Mapper write in this CPU cycle
	logic [2:0] reg_sel;      // A14:13 then A0
	bank_sel_t  bank_select;  // Target of the next bank data write

	// Only $8000 and up belongs to the mapper registers
	assign reg_wr  = ce && prg_write && prg_ain[15];
	assign reg_sel = {prg_ain[14:13], prg_ain[0]};

	// IRQ block keeps its own state, it only sees these strobes
	assign irq_latch_wr   = reg_wr && (reg_sel == 3'b10_0);
	assign irq_reload_wr  = reg_wr && (reg_sel == 3'b10_1);
	assign irq_disable_wr = reg_wr && (reg_sel == 3'b11_0);
	assign irq_enable_wr  = reg_wr && (reg_sel == 3'b11_1);
	assign irq_latch_val  = prg_din;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bank_select  <= '0;
			prg_mode     <= 1'b0;
			chr_invert   <= 1'b0;
			mirror_horiz <= 1'b0;           // Vertical
			ram_enable   <= 1'b0;
			ram_protect  <= 1'b0;
			prg_bank_0   <= '0;
			prg_bank_1   <= '0;
			chr_bank_0   <= '0;
			chr_bank_1   <= '0;
			chr_bank_2   <= '0;
			chr_bank_3   <= '0;
			chr_bank_4   <= '0;
			chr_bank_5   <= '0;
		end else if (reg_wr) begin
			case (reg_sel)
				3'b00_0: begin              // Bank select
					chr_invert  <= prg_din[7];
					prg_mode    <= prg_din[6];
					bank_select <= prg_din[2:0];
				end
				3'b00_1: begin              // Bank data
					case (bank_select)
						// 2 KB banks ignore bit 0, A10 fills it later
						3'd0: chr_bank_0 <= {prg_din[7:1], 1'b0};
						3'd1: chr_bank_1 <= {prg_din[7:1], 1'b0};
						3'd2: chr_bank_2 <= prg_din;
						3'd3: chr_bank_3 <= prg_din;
						3'd4: chr_bank_4 <= prg_din;
						3'd5: chr_bank_5 <= prg_din;
						3'd6: prg_bank_0 <= prg_din[5:0];    // Upper bits unused
						3'd7: prg_bank_1 <= prg_din[5:0];
					endcase
				end
				3'b01_0: begin              // Mirroring
					mirror_horiz <= prg_din[0];
				end
				3'b01_1: begin              // PRG RAM protect
					ram_enable  <= prg_din[7];
					ram_protect <= prg_din[6];
				end
				default: begin              // IRQ registers, strobes only
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/mmc3_pkg.sv */
// --------------------
// MMC3 shared widths, bank types and memory-map constants
// --------------------
`default_nettype none

package mmc3_pkg;

	// Bus widths
	localparam int CPU_ADDR_W = 16;     // CPU address bus
	localparam int PPU_ADDR_W = 14;     // PPU address bus
	localparam int OUT_ADDR_W = 22;     // Flat cartridge memory space

	typedef logic [CPU_ADDR_W-1:0] cpu_addr_t;
	typedef logic [PPU_ADDR_W-1:0] ppu_addr_t;
	typedef logic [OUT_ADDR_W-1:0] out_addr_t;

	// Bank indices
	typedef logic [5:0] prg_bank_t;     // 8 KB PRG bank, 64 banks
	typedef logic [7:0] chr_bank_t;     // 1 KB CHR bank, 256 banks
	typedef logic [2:0] bank_sel_t;     // Bank data target R0-R7

	// Fixed PRG banks
	localparam prg_bank_t PRG_LAST_BANK   = 6'b111111;  // Always at $E000
	localparam prg_bank_t PRG_SECOND_LAST = 6'b111110;  // $C000 or $8000 by mode

	// Region prefixes in the flat space
	// PRG ROM starts at zero, CHR sits above it and PRG RAM at the very top
	localparam logic [8:0] PRG_RAM_BASE = 9'b111100000; // Followed by A12:0
	localparam logic [2:0] CHR_BASE     = 3'b100;       // Followed by bank and A9:0

endpackage

`default_nettype wire
